//--- logic/matmul_pkg.sv
package matmul_pkg;

  //////////////////////////////////////////////////
  // Sizes and widths
  //////////////////////////////////////////////////

  localparam int DWIDTH            = 8;
  localparam int AWIDTH            = 7;
  localparam int MEM_SIZE          = 128;
  localparam int MAT_MUL_SIZE      = 4;
  localparam int LOG2_MAT_MUL_SIZE = 2;

  // Edges from accepted start to the edge that raises done
  localparam int MAC_LATENCY = 6;

  //////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////

  typedef logic [DWIDTH-1:0] elem_t;

  // One bank word, one host word, one C row. Element 0 in the low byte
  typedef elem_t [MAT_MUL_SIZE-1:0] row_t;

  // Whole C tile, row 0 lowest
  typedef row_t [MAT_MUL_SIZE-1:0] tile_t;

  typedef struct packed {
    logic              enable_writing_to_mem;
    logic              enable_reading_from_mem;
    logic              we_a;
    logic              we_b;
    logic [AWIDTH-1:0] addr;
    row_t              data;
  } host_req_t;

  typedef struct packed {
    logic clear;
    logic accumulate;
  } mac_ctrl_t;

endpackage

//--- logic/operand_bank.sv
`timescale 1ns/100ps

module operand_bank
  import matmul_pkg::*;
(
  input  logic              clk_mem,
  input  logic [AWIDTH-1:0] addr,
  input  row_t              wdata,
  input  logic              we,
  output row_t              rdata
);

  // Single-port storage, one row_t per address
  row_t mem [MEM_SIZE];

  //////////////////////////////////////////////////
  // Write port and registered read
  //////////////////////////////////////////////////

  // A write cycle returns the old word at that address
  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- logic/host_port.sv
`timescale 1ns/100ps

module host_port
  import matmul_pkg::*;
(
  input  logic                         clk_mem,
  input  logic                         reset,
  input  host_req_t                    host,
  input  logic                         busy,
  input  logic [LOG2_MAT_MUL_SIZE-1:0] rd_addr,
  output host_req_t                    req,
  output row_t                         a_col,
  output row_t                         b_row
);

  logic              we_a_bank;
  logic              we_b_bank;
  logic [AWIDTH-1:0] bank_addr;

  //////////////////////////////////////////////////
  // Host request register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      req <= '0;
    end else begin
      req <= host;
    end
  end

  // Host writes are locked out during a run
  assign we_a_bank = req.enable_writing_to_mem & req.we_a & ~busy;
  assign we_b_bank = req.enable_writing_to_mem & req.we_b & ~busy;

  // Sequencer owns both banks while busy
  assign bank_addr = busy ? AWIDTH'(rd_addr) : req.addr;

  //////////////////////////////////////////////////
  // Operand banks
  //////////////////////////////////////////////////

  // Columns of A
  operand_bank u_a_bank (
    .clk_mem (clk_mem),
    .addr    (bank_addr),
    .wdata   (req.data),
    .we      (we_a_bank),
    .rdata   (a_col)
  );

  // Rows of B
  operand_bank u_b_bank (
    .clk_mem (clk_mem),
    .addr    (bank_addr),
    .wdata   (req.data),
    .we      (we_b_bank),
    .rdata   (b_row)
  );

endmodule

//--- logic/tile_sequencer.sv
`timescale 1ns/100ps

module tile_sequencer
  import matmul_pkg::*;
(
  input  logic                         clk_mem,
  input  logic                         reset,
  input  logic                         start_mat_mul,
  output logic                         busy,
  output logic [LOG2_MAT_MUL_SIZE-1:0] rd_addr,
  output mac_ctrl_t                    mac_ctrl,
  output logic                         tile_write,
  output logic                         done_mat_mul
);

  // Holds n after edge n of a run, counted from the accepting edge
  logic [2:0] step;

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      busy <= 1'b0;
      step <= '0;
    end else if (!busy) begin
      // Start only taken between runs
      if (start_mat_mul) begin
        busy <= 1'b1;
        step <= '0;
      end
    end else begin
      step <= step + 3'd1;
      if (step == 3'(MAC_LATENCY - 1)) begin
        busy <= 1'b0;
      end
    end
  end

  // k follows the step count for the first four steps
  assign rd_addr = step[LOG2_MAT_MUL_SIZE-1:0];

  //////////////////////////////////////////////////
  // MAC controls, tile write and done
  //////////////////////////////////////////////////

  // Delayed by one edge to line up with the bank read data
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      mac_ctrl     <= '0;
      tile_write   <= 1'b0;
      done_mat_mul <= 1'b0;
    end else begin
      mac_ctrl.accumulate <= busy && (step < 3'(MAT_MUL_SIZE));
      mac_ctrl.clear      <= busy && (step == 3'd0);
      tile_write          <= busy && (step == 3'(MAC_LATENCY - 2));
      done_mat_mul        <= busy && (step == 3'(MAC_LATENCY - 1));
    end
  end

endmodule

//--- logic/mac_array.sv
`timescale 1ns/100ps

module mac_array
  import matmul_pkg::*;
(
  input  logic      clk_mem,
  input  logic      reset,
  input  mac_ctrl_t mac_ctrl,
  input  row_t      a_col,
  input  row_t      b_row,
  output tile_t     tile
);

  elem_t acc [MAT_MUL_SIZE][MAT_MUL_SIZE];

  //////////////////////////////////////////////////
  // Outer-product accumulators
  //////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_MUL_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_MUL_SIZE; j++) begin : g_col
      elem_t prod;

      // Product kept to 8 bits, wraps modulo 256
      assign prod = elem_t'(a_col[i] * b_row[j]);

      always_ff @(posedge clk_mem) begin
        if (reset) begin
          acc[i][j] <= '0;
        end else if (mac_ctrl.accumulate) begin
          // First k loads the product
          acc[i][j] <= (mac_ctrl.clear ? elem_t'(0) : acc[i][j]) + prod;
        end
      end
    end
  end

  // Pack running sums into the tile word
  always_comb begin
    for (int i = 0; i < MAT_MUL_SIZE; i++) begin
      for (int j = 0; j < MAT_MUL_SIZE; j++) begin
        tile[i][j] = acc[i][j];
      end
    end
  end

endmodule

//--- logic/result_bank.sv
`timescale 1ns/100ps

module result_bank
  import matmul_pkg::*;
(
  input  logic      clk_mem,
  input  logic      reset,
  input  tile_t     tile,
  input  logic      tile_write,
  input  host_req_t req,
  output row_t      data_from_out_mat
);

  // Last completed C tile
  tile_t c_tile;

  //////////////////////////////////////////////////
  // Tile capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      c_tile <= '0;
    end else if (tile_write) begin
      c_tile <= tile;
    end
  end

  //////////////////////////////////////////////////
  // Row read mux
  //////////////////////////////////////////////////

  // Output holds between reads
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      data_from_out_mat <= '0;
    end else if (req.enable_reading_from_mem) begin
      data_from_out_mat <= c_tile[req.addr[LOG2_MAT_MUL_SIZE-1:0]];
    end
  end

endmodule

//--- logic/matrix_multiplication.sv
`timescale 1ns/100ps

module matrix_multiplication
  import matmul_pkg::*;
(
  input  logic              clk_mem,
  input  logic              reset,
  input  logic              enable_writing_to_mem,
  input  logic              enable_reading_from_mem,
  input  row_t              data_pi,
  input  logic [AWIDTH-1:0] addr_pi,
  input  logic              we_a,
  input  logic              we_b,
  input  logic              start_mat_mul,
  output row_t              data_from_out_mat,
  output logic              done_mat_mul
);

  host_req_t                    host;
  host_req_t                    req;
  row_t                         a_col;
  row_t                         b_row;
  logic                         busy;
  logic [LOG2_MAT_MUL_SIZE-1:0] rd_addr;
  mac_ctrl_t                    mac_ctrl;
  tile_t                        tile;
  logic                         tile_write;

  // Bundle the host pins
  assign host = '{
    enable_writing_to_mem:   enable_writing_to_mem,
    enable_reading_from_mem: enable_reading_from_mem,
    we_a:                    we_a,
    we_b:                    we_b,
    addr:                    addr_pi,
    data:                    data_pi
  };

  //////////////////////////////////////////////////
  // Input side, control and compute
  //////////////////////////////////////////////////

  host_port u_host_port (
    .clk_mem (clk_mem),
    .reset   (reset),
    .host    (host),
    .busy    (busy),
    .rd_addr (rd_addr),
    .req     (req),
    .a_col   (a_col),
    .b_row   (b_row)
  );

  tile_sequencer u_tile_sequencer (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .busy          (busy),
    .rd_addr       (rd_addr),
    .mac_ctrl      (mac_ctrl),
    .tile_write    (tile_write),
    .done_mat_mul  (done_mat_mul)
  );

  mac_array u_mac_array (
    .clk_mem  (clk_mem),
    .reset    (reset),
    .mac_ctrl (mac_ctrl),
    .a_col    (a_col),
    .b_row    (b_row),
    .tile     (tile)
  );

  // Output side
  result_bank u_result_bank (
    .clk_mem           (clk_mem),
    .reset             (reset),
    .tile              (tile),
    .tile_write        (tile_write),
    .req               (req),
    .data_from_out_mat (data_from_out_mat)
  );

endmodule

//--- testbench/matmul_properties.sv
`timescale 1ns/100ps

module matmul_properties
  import matmul_pkg::*;
(
  input logic clk_mem,
  input logic reset,
  input logic start_mat_mul,
  input logic busy,
  input logic tile_write,
  input logic done_mat_mul
);

  int fail_count = 0;

  // Done is a single-cycle pulse
  a_done_pulse : assert property (@(posedge clk_mem) disable iff (reset)
      done_mat_mul |=> !done_mat_mul)
    else begin
      fail_count++;
      $error("done_mat_mul high for two cycles in a row");
    end

  // Set on edge MAC_LATENCY of the run, seen at the sample after it
  a_done_latency : assert property (@(posedge clk_mem) disable iff (reset)
      (start_mat_mul && !busy) |=> ##MAC_LATENCY $rose(done_mat_mul))
    else begin
      fail_count++;
      $error("done_mat_mul not raised MAC_LATENCY edges after an accepted start");
    end

  a_write_then_done : assert property (@(posedge clk_mem) disable iff (reset)
      tile_write |=> done_mat_mul)
    else begin
      fail_count++;
      $error("tile_write not followed by done_mat_mul");
    end

endmodule

bind tile_sequencer matmul_properties u_matmul_properties (.*);

//--- testbench/tb_matrix_multiplication.sv
`timescale 1ns/100ps

module tb_matrix_multiplication
  import matmul_pkg::*;
();

  logic              clk_mem;
  logic              reset;
  logic              enable_writing_to_mem;
  logic              enable_reading_from_mem;
  row_t              data_pi;
  logic [AWIDTH-1:0] addr_pi;
  logic              we_a;
  logic              we_b;
  logic              start_mat_mul;
  row_t              data_from_out_mat;
  logic              done_mat_mul;

  integer seed = 32'h129d_f66b;
  int     done_count = 0;

  matrix_multiplication u_matrix_multiplication (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .start_mat_mul           (start_mat_mul),
    .data_from_out_mat       (data_from_out_mat),
    .done_mat_mul            (done_mat_mul)
  );

  initial begin
    clk_mem = 1'b0;
    forever #5 clk_mem = ~clk_mem;
  end

  // Done pulses seen between edges
  always @(negedge clk_mem) begin
    if (done_mat_mul) begin
      done_count++;
    end
  end

  // Sequencer assertion failures
  always @(negedge clk_mem) begin
    if (u_matrix_multiplication.u_tile_sequencer.u_matmul_properties.fail_count != 0) begin
      fail_run("A sequencer assertion failed");
    end
  end

  //////////////////////////////////////////////////
  // Reference model and compare
  //////////////////////////////////////////////////

  // C[i][j] = sum over k of A[i][k] * B[k][j], modulo 256
  function automatic tile_t mat_product(input tile_t a_cols, input tile_t b_rows);
    tile_t c;
    int    acc;
    for (int i = 0; i < MAT_MUL_SIZE; i++) begin
      for (int j = 0; j < MAT_MUL_SIZE; j++) begin
        acc = 0;
        for (int k = 0; k < MAT_MUL_SIZE; k++) begin
          acc += int'(a_cols[k][i]) * int'(b_rows[k][j]);
        end
        c[i][j] = elem_t'(acc);
      end
    end
    return c;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_values(input string name, input logic [127:0] exp_val,
                                input logic [127:0] act_val);
    if (exp_val !== act_val) begin
      fail_run($sformatf("FAILED %s: expected %0h, actual %0h", name, exp_val, act_val));
    end
  endtask

  // Load A and B, run one tile and read back every C row
  task automatic run_test(input string name, input tile_t a, input tile_t b,
                          input tile_t exp_tile, input bit restart);
    row_t got;
    bit   seen;
    for (int k = 0; k < 2 * MAT_MUL_SIZE; k++) begin
      @(posedge clk_mem);
      enable_writing_to_mem <= 1'b1;
      we_a    <= ~k[0];
      we_b    <= k[0];
      addr_pi <= AWIDTH'(k / 2);
      data_pi <= k[0] ? b[k/2] : a[k/2];
    end
    @(posedge clk_mem);
    enable_writing_to_mem <= 1'b0;
    start_mat_mul         <= 1'b1;
    @(posedge clk_mem);
    start_mat_mul <= 1'b0;
    // Extra start two cycles into the run
    if (restart) begin
      @(posedge clk_mem);
      start_mat_mul <= 1'b1;
      @(posedge clk_mem);
      start_mat_mul <= 1'b0;
    end
    seen = 1'b0;
    for (int cycle = 0; cycle < 20 && !seen; cycle++) begin
      @(negedge clk_mem);
      seen = done_mat_mul;
    end
    if (!seen) begin
      fail_run($sformatf("Timeout: no done_mat_mul within 20 cycles in test %s", name));
    end
    // Row appears two edges after the request
    for (int i = 0; i < MAT_MUL_SIZE; i++) begin
      @(posedge clk_mem);
      enable_reading_from_mem <= 1'b1;
      addr_pi                 <= AWIDTH'(i);
      @(posedge clk_mem);
      enable_reading_from_mem <= 1'b0;
      @(posedge clk_mem);
      @(negedge clk_mem);
      got = data_from_out_mat;
      compare_values($sformatf("%s row %0d", name, i), 128'(exp_tile[i]), 128'(got));
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    tile_t a;
    tile_t b;
    tile_t exp_tile;
    int    count_before;
    reset                   <= 1'b1;
    enable_writing_to_mem   <= 1'b0;
    enable_reading_from_mem <= 1'b0;
    data_pi                 <= '0;
    addr_pi                 <= '0;
    we_a                    <= 1'b0;
    we_b                    <= 1'b0;
    start_mat_mul           <= 1'b0;
    repeat (8) @(posedge clk_mem);
    reset <= 1'b0;
    @(negedge clk_mem);
    compare_values("reset done", 128'(0), 128'(done_mat_mul));
    compare_values("reset data", 128'(0), 128'(data_from_out_mat));

    for (int k = 0; k < MAT_MUL_SIZE; k++) begin
      a[k] = $random(seed);
      b[k] = $random(seed);
    end
    run_test("random", a, b, mat_product(a, b), 1'b0);

    // Identity B gives C = A, rebuilt from the stored columns
    for (int k = 0; k < MAT_MUL_SIZE; k++) begin
      b[k]    = '0;
      b[k][k] = 8'd1;
      for (int i = 0; i < MAT_MUL_SIZE; i++) begin
        exp_tile[i][k] = a[k][i];
      end
    end
    run_test("identity", a, b, exp_tile, 1'b0);

    // 255 * 255 = 1 mod 256, four terms give 4
    run_test("wraparound", '1, '1, {16{8'h04}}, 1'b0);

    for (int k = 0; k < MAT_MUL_SIZE; k++) begin
      a[k] = $random(seed);
      b[k] = $random(seed);
    end
    exp_tile     = mat_product(a, b);
    count_before = done_count;
    run_test("restart", a, b, exp_tile, 1'b1);
    @(posedge clk_mem);
    compare_values("single done", 128'(count_before + 1), 128'(done_count));

    // Output keeps row 3 with reads off and a new address
    @(posedge clk_mem);
    addr_pi <= AWIDTH'(1);
    repeat (3) @(posedge clk_mem);
    @(negedge clk_mem);
    compare_values("hold", 128'(exp_tile[3]), 128'(data_from_out_mat));

    if (u_matrix_multiplication.u_tile_sequencer.u_matmul_properties.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- all.f
logic/matmul_pkg.sv
logic/operand_bank.sv
logic/host_port.sv
logic/tile_sequencer.sv
logic/mac_array.sv
logic/result_bank.sv
logic/matrix_multiplication.sv
testbench/matmul_properties.sv
testbench/tb_matrix_multiplication.sv

//--- Makefile
TOP       ?= tb_matrix_multiplication
SEED      ?= 1
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f

.PHONY: all lint clean

all:
	$(VERILATOR) --binary --assert -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+error+limit+100 > $(LOG) 2>&1; \
	cat $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
